/* bin2x2.f */
+incdir+.
bin2x2_pkg.sv
video_if.sv
wb_csr_regs.sv
frame_mode_fsm.sv
pix_line_counter.sv
line_buffer.sv
bin_avg_pipe.sv
bin2x2_top.sv
bin2x2_assertions.sv
bin2x2_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= bin2x2_tb
FILELIST   ?= bin2x2.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= *** PASSED ***

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bin2x2_tb.sv */
// testbench for the 2x2 binning block; drives frames and wishbone, prints one line per test
`timescale 1ns/100ps
`include "bin2x2_consts.svh"

module bin2x2_tb
    import bin2x2_pkg::*;
();

    localparam int FW        = 16;
    localparam int FH        = 8;
    localparam int BLANK     = 4;
    localparam int GAP       = 8;
    localparam int ACK_TMO   = 16;
    localparam int DRAIN_TMO = 200;

    logic                            clk;
    logic                            rst_n_i;
    logic [`BIN_PIXEL_WIDTH-1:0]     pix_data_i;
    logic                            pix_de_i;
    logic                            pix_hs_i;
    logic                            pix_vs_i;
    logic [`BIN_PIXEL_WIDTH-1:0]     pix_data_o;
    logic                            pix_de_o;
    logic                            pix_hs_o;
    logic                            pix_vs_o;
    logic                            wb_cyc_i;
    logic                            wb_stb_i;
    logic                            wb_we_i;
    logic [`BIN_WB_ADDR_WIDTH-1:0]   wb_adr_i;
    logic [`BIN_WB_DATA_WIDTH-1:0]   wb_dat_i;
    logic [`BIN_WB_DATA_WIDTH/8-1:0] wb_sel_i;
    logic [`BIN_WB_DATA_WIDTH-1:0]   wb_dat_o;
    logic                            wb_ack_o;

    integer                        seed;
    int                            err_cnt;
    int                            test_cnt;
    int                            test_fail;
    int                            test_base;
    int                            out_cnt;
    int                            hs_cnt;
    int                            in_cnt;
    logic [`BIN_WB_DATA_WIDTH-1:0] rd_val;
    // expected output pixels, oldest first
    logic [`BIN_PIXEL_WIDTH-1:0]   exp_q [$];
    logic [`BIN_PIXEL_WIDTH-1:0]   frame_pix [0:FH-1][0:FW-1];

    bin2x2_top UUT (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pix_data_i (pix_data_i),
        .pix_de_i   (pix_de_i),
        .pix_hs_i   (pix_hs_i),
        .pix_vs_i   (pix_vs_i),
        .pix_data_o (pix_data_o),
        .pix_de_o   (pix_de_o),
        .pix_hs_o   (pix_hs_o),
        .pix_vs_o   (pix_vs_o),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_sel_i   (wb_sel_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o)
    );

    always #2 clk = ~clk;

    // ------------------------------
    // helpers
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (5) @(posedge clk);
        #0.5;
        rst_n_i = 1'b1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic wb_access(input logic we, input csr_addr_e adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        n = 0;
        rdat = '0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        wb_sel_i = 4'hf;
        next_cycle();
        while (!wb_ack_o && n < ACK_TMO) begin
            next_cycle();
            n++;
        end
        if (wb_ack_o) begin
            rdat = wb_dat_o;
        end else begin
            $display("no wishbone ack within %0d cycles", ACK_TMO);
            err_cnt++;
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        next_cycle();
    endtask

    task automatic wb_write(input csr_addr_e adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input csr_addr_e adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    // one FW x FH frame; rule says what the output should carry
    task automatic send_frame(input out_mode_e rule);
        logic [31:0]                 rnd;
        logic [`BIN_PIXEL_WIDTH+1:0] sum;
        pix_vs_i = 1'b1;
        next_cycle();
        for (int l = 0; l < FH; l++) begin
            pix_hs_i = 1'b1;
            next_cycle();
            pix_hs_i = 1'b0;
            for (int c = 0; c < FW; c++) begin
                rnd = $random(seed);
                frame_pix[l][c] = rnd[`BIN_PIXEL_WIDTH-1:0];
                pix_data_i = rnd[`BIN_PIXEL_WIDTH-1:0];
                pix_de_i = 1'b1;
                in_cnt++;
                if (rule == MODE_PASS) begin
                    exp_q.push_back(frame_pix[l][c]);
                end
                // square closes on the odd column of an odd line
                if (rule == MODE_BIN && (l % 2) == 1 && (c % 2) == 1) begin
                    sum = {2'b00, frame_pix[l-1][c-1]} + {2'b00, frame_pix[l-1][c]}
                        + {2'b00, frame_pix[l][c-1]} + {2'b00, frame_pix[l][c]};
                    exp_q.push_back(sum[`BIN_PIXEL_WIDTH+1:2]);
                end
                next_cycle();
            end
            pix_de_i = 1'b0;
            pix_data_i = '0;
            repeat (BLANK) next_cycle();
        end
        pix_vs_i = 1'b0;
        repeat (GAP) next_cycle();
    endtask

    task automatic start_test();
        out_cnt = 0;
        hs_cnt = 0;
        in_cnt = 0;
        test_base = err_cnt + UUT.u_assert.fail_cnt;
    endtask

    task automatic drain_output();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_TMO) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected pixels never appeared on the output", exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
        repeat (4) next_cycle();
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = err_cnt + UUT.u_assert.fail_cnt - test_base;
        test_cnt++;
        if (errs != 0) begin
            test_fail++;
        end
        $display("test %0d, %s: %s (%0d errors)", test_cnt, name,
                 (errs == 0) ? "ok" : "bad", errs);
    endtask

    // ------------------------------
    // output monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (pix_hs_o) begin
                hs_cnt++;
            end
            if (pix_de_o) begin
                out_cnt++;
                if (exp_q.size() == 0) begin
                    $display("output pixel 0x%0h came out with nothing expected", pix_data_o);
                    err_cnt++;
                end else begin
                    check_value("pix_data_o", 32'(pix_data_o), 32'(exp_q.pop_front()));
                end
            end
        end
    end

    initial begin
        seed = 32'h591a_ee35;
        clk = 1'b0;
        rst_n_i = 1'b0;
        pix_data_i = '0;
        pix_de_i = 1'b0;
        pix_hs_i = 1'b0;
        pix_vs_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        err_cnt = 0;
        test_cnt = 0;
        test_fail = 0;
        test_base = 0;
        out_cnt = 0;
        hs_cnt = 0;
        in_cnt = 0;
        apply_reset();

        // off after reset
        start_test();
        wb_read(REG_CTRL, rd_val);
        check_value("REG_CTRL", rd_val, 32'h0);
        send_frame(MODE_OFF);
        drain_output();
        check_value("output pixel count", out_cnt, 0);
        report_test("idle after reset");

        start_test();
        wb_write(REG_CTRL, 32'h1);
        repeat (2) next_cycle();
        send_frame(MODE_BIN);
        drain_output();
        check_value("binned pixel count", out_cnt, FW * FH / 4);
        check_value("output hs count", hs_cnt, FH / 2);
        report_test("binning 16x8");

        start_test();
        wb_write(REG_CTRL, 32'h3);
        repeat (2) next_cycle();
        send_frame(MODE_PASS);
        drain_output();
        check_value("bypass pixel count", out_cnt, in_cnt);
        check_value("output hs count", hs_cnt, FH);
        report_test("bypass");

        // switch back to binning while line 2 is running
        start_test();
        fork
            send_frame(MODE_PASS);
            begin
                repeat (40) next_cycle();
                wb_write(REG_CTRL, 32'h1);
            end
        join
        send_frame(MODE_BIN);
        drain_output();
        check_value("output pixel count", out_cnt, FW * FH + FW * FH / 4);
        report_test("mode change mid-frame");

        start_test();
        apply_reset();
        wb_write(REG_CTRL, 32'h1);
        repeat (2) next_cycle();
        send_frame(MODE_BIN);
        send_frame(MODE_BIN);
        drain_output();
        wb_read(REG_WIDTH, rd_val);
        check_value("REG_WIDTH", rd_val, FW);
        wb_read(REG_HEIGHT, rd_val);
        check_value("REG_HEIGHT", rd_val, FH);
        wb_read(REG_FRAMES, rd_val);
        check_value("REG_FRAMES", rd_val, 32'd2);
        wb_write(REG_FRAMES, 32'ha5);
        wb_read(REG_FRAMES, rd_val);
        check_value("REG_FRAMES", rd_val, 32'd2);
        check_value("binned pixel count", out_cnt, FW * FH / 2);
        report_test("status registers");

        $display("tests: %0d run, %0d failed, %0d errors", test_cnt, test_fail,
                 err_cnt + UUT.u_assert.fail_cnt);
        if (test_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* bin2x2_assertions.sv */
// concurrent checks on the output stream and the wishbone slave, bound into the top level
`timescale 1ns/100ps
`include "bin2x2_consts.svh"

module bin2x2_assertions
    import bin2x2_pkg::*;
(
    input logic                        clk,
    input logic                        rst_n_i,
    input out_mode_e                   mode_i,
    input logic [`BIN_PIXEL_WIDTH-1:0] pix_data_i,
    input logic                        pix_de_i,
    input logic                        pix_hs_i,
    input logic                        pix_vs_i,
    input logic [`BIN_PIXEL_WIDTH-1:0] pix_data_o,
    input logic                        pix_de_o,
    input logic                        pix_hs_o,
    input logic                        pix_vs_o,
    input logic                        wb_cyc_i,
    input logic                        wb_stb_i,
    input logic                        wb_ack_o
);

    // failures so far, read by the testbench
    int fail_cnt = 0;

    // ------------------------------
    // wishbone
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("wishbone ack held longer than one cycle");
    end

    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("wishbone request not acked on the next cycle");
    end

    // ------------------------------
    // output stream
    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !(pix_de_o || pix_hs_o || pix_vs_o || wb_ack_o))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("outputs active right after reset");
    end

    de_inside_frame: assert property (@(posedge clk) disable iff (!rst_n_i)
        pix_de_o |-> pix_vs_o)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("output de high while output vs is low");
    end

    // the mux register used the mode of the previous edge
    bypass_delay: assert property (@(posedge clk) disable iff (!rst_n_i)
        ($past(mode_i) == MODE_PASS) |->
            (pix_data_o == $past(pix_data_i)) && (pix_de_o == $past(pix_de_i)) &&
            (pix_hs_o == $past(pix_hs_i)) && (pix_vs_o == $past(pix_vs_i)))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("bypass output differs from the input one cycle earlier");
    end

endmodule

bind bin2x2_top bin2x2_assertions u_assert (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .mode_i     (mode),
    .pix_data_i (pix_data_i),
    .pix_de_i   (pix_de_i),
    .pix_hs_i   (pix_hs_i),
    .pix_vs_i   (pix_vs_i),
    .pix_data_o (pix_data_o),
    .pix_de_o   (pix_de_o),
    .pix_hs_o   (pix_hs_o),
    .pix_vs_o   (pix_vs_o),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_ack_o   (wb_ack_o)
);

/* bin2x2_top.sv */
// top level of the 2x2 binning block, plain video and wishbone ports
`timescale 1ns/100ps
`include "bin2x2_consts.svh"

module bin2x2_top
    import bin2x2_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [`BIN_PIXEL_WIDTH-1:0]     pix_data_i,
    input  logic                            pix_de_i,
    input  logic                            pix_hs_i,
    input  logic                            pix_vs_i,
    output logic [`BIN_PIXEL_WIDTH-1:0]     pix_data_o,
    output logic                            pix_de_o,
    output logic                            pix_hs_o,
    output logic                            pix_vs_o,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [`BIN_WB_ADDR_WIDTH-1:0]   wb_adr_i,
    input  logic [`BIN_WB_DATA_WIDTH-1:0]   wb_dat_i,
    input  logic [`BIN_WB_DATA_WIDTH/8-1:0] wb_sel_i,
    output logic [`BIN_WB_DATA_WIDTH-1:0]   wb_dat_o,
    output logic                            wb_ack_o
);

    video_if vin ();
    video_if vout ();

    pix_pos_t                      pos;
    out_mode_e                     mode;
    logic                          frame_gap;
    logic                          ctrl_en;
    logic                          ctrl_bypass;
    logic [`BIN_WB_DATA_WIDTH-1:0] frames;
    logic [`BIN_COL_WIDTH-1:0]     width;
    logic [`BIN_COL_WIDTH-1:0]     height;
    logic [`BIN_PIXEL_WIDTH-1:0]   prev_pix;

    // ------------------------------
    // stream in and out
    assign vin.data = pix_data_i;
    assign vin.de   = pix_de_i;
    assign vin.hs   = pix_hs_i;
    assign vin.vs   = pix_vs_i;

    assign pix_data_o = vout.data;
    assign pix_de_o   = vout.de;
    assign pix_hs_o   = vout.hs;
    assign pix_vs_o   = vout.vs;

    wb_csr_regs u_csr (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (csr_addr_e'(wb_adr_i)),
        .wb_dat_i      (wb_dat_i),
        .wb_sel_i      (wb_sel_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .frames_i      (frames),
        .width_i       (width),
        .height_i      (height),
        .ctrl_en_o     (ctrl_en),
        .ctrl_bypass_o (ctrl_bypass)
    );

    frame_mode_fsm u_fsm (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ctrl_en_i     (ctrl_en),
        .ctrl_bypass_i (ctrl_bypass),
        .frame_gap_i   (frame_gap),
        .mode_o        (mode)
    );

    pix_line_counter u_cnt (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .vin         (vin.snk),
        .mode_i      (mode),
        .pos_o       (pos),
        .frame_gap_o (frame_gap),
        .frames_o    (frames),
        .width_o     (width),
        .height_o    (height)
    );

    // written on every input pixel
    line_buffer u_lbuf (
        .clk        (clk),
        .vin_data_i (vin.data),
        .we_i       (vin.de),
        .pos_i      (pos),
        .prev_o     (prev_pix)
    );

    bin_avg_pipe u_pipe (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .vin     (vin.snk),
        .prev_i  (prev_pix),
        .pos_i   (pos),
        .mode_i  (mode),
        .vout    (vout.src)
    );

endmodule

/* bin_avg_pipe.sv */
// 2x2 averaging pipeline with output mode mux for binned, bypass or blanked video
`timescale 1ns/100ps
`include "bin2x2_consts.svh"

module bin_avg_pipe
    import bin2x2_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n_i,
    video_if.snk                        vin,
    input  logic [`BIN_PIXEL_WIDTH-1:0] prev_i,
    input  pix_pos_t                    pos_i,
    input  out_mode_e                   mode_i,
    video_if.src                        vout
);

    // held even-column pixels, current and previous line
    logic [`BIN_PIXEL_WIDTH-1:0] cur_even;
    logic [`BIN_PIXEL_WIDTH-1:0] prev_even;
    logic [`BIN_PIXEL_WIDTH:0]   sum_cur;
    logic [`BIN_PIXEL_WIDTH+1:0] sum_all;
    logic                        v1;
    logic                        v2;
    logic                        hs1;
    logic                        hs2;
    logic                        vs1;
    logic                        vs2;

    // ------------------------------
    // data stages
    always_ff @(posedge clk) begin
        if (vin.de && !pos_i.col_odd) begin
            cur_even <= vin.data;
        end
        // buffer output lags by a cycle, so it still shows the even column here
        if (vin.de && pos_i.col_odd) begin
            prev_even <= prev_i;
            sum_cur   <= {1'b0, cur_even} + {1'b0, vin.data};
        end
        // prev_i now holds the odd column of the previous line
        sum_all <= {1'b0, sum_cur} + {2'b00, prev_even} + {2'b00, prev_i};
    end

    // ------------------------------
    // valid and sync alignment
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            v1  <= 1'b0;
            v2  <= 1'b0;
            hs1 <= 1'b0;
            hs2 <= 1'b0;
            vs1 <= 1'b0;
            vs2 <= 1'b0;
        end else begin
            v1  <= vin.de & pos_i.col_odd & pos_i.line_odd;
            v2  <= v1;
            // line pulse kept only for lines that close a square
            hs1 <= pos_i.line_start & pos_i.line_odd;
            hs2 <= hs1;
            vs1 <= vin.vs;
            vs2 <= vs1;
        end
    end

    // ------------------------------
    // output mux registers
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vout.de <= 1'b0;
            vout.hs <= 1'b0;
            vout.vs <= 1'b0;
        end else begin
            case (mode_i)
                MODE_BIN: begin
                    vout.de <= v2;
                    vout.hs <= hs2;
                    vout.vs <= vs2;
                end
                MODE_PASS: begin
                    vout.de <= vin.de;
                    vout.hs <= vin.hs;
                    vout.vs <= vin.vs;
                end
                default: begin
                    vout.de <= 1'b0;
                    vout.hs <= 1'b0;
                    vout.vs <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (mode_i)
            // floor of the sum over four
            MODE_BIN:  vout.data <= sum_all[`BIN_PIXEL_WIDTH+1:2];
            MODE_PASS: vout.data <= vin.data;
            default:   vout.data <= '0;
        endcase
    end

endmodule

/* line_buffer.sv */
// one line of pixel storage; read-before-write returns the previous line, same column
`timescale 1ns/100ps
`include "bin2x2_consts.svh"

module line_buffer
    import bin2x2_pkg::*;
(
    input  logic                        clk,
    input  logic [`BIN_PIXEL_WIDTH-1:0] vin_data_i,
    input  logic                        we_i,
    input  pix_pos_t                    pos_i,
    output logic [`BIN_PIXEL_WIDTH-1:0] prev_o
);

    logic [`BIN_PIXEL_WIDTH-1:0]      mem [0:`BIN_LINE_MAX-1];
    logic [$clog2(`BIN_LINE_MAX)-1:0] addr;

    // longer lines wrap, not supported
    assign addr = pos_i.col[$clog2(`BIN_LINE_MAX)-1:0];

    // old word out, new word in, single port
    always_ff @(posedge clk) begin
        if (we_i) begin
            prev_o    <= mem[addr];
            mem[addr] <= vin_data_i;
        end
    end

endmodule

/* pix_line_counter.sv */
// column, line and frame counters; gives the pixel position and measures the frame size
`timescale 1ns/100ps
`include "bin2x2_consts.svh"

module pix_line_counter
    import bin2x2_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n_i,
    video_if.snk                          vin,
    input  out_mode_e                     mode_i,
    output pix_pos_t                      pos_o,
    output logic                          frame_gap_o,
    output logic [`BIN_WB_DATA_WIDTH-1:0] frames_o,
    output logic [`BIN_COL_WIDTH-1:0]     width_o,
    output logic [`BIN_COL_WIDTH-1:0]     height_o
);

    logic [`BIN_COL_WIDTH-1:0] col_cnt;
    logic [`BIN_COL_WIDTH-1:0] line_cnt;
    logic                      de_q;
    logic                      vs_q;
    logic                      line_end;
    logic                      frame_end;

    assign line_end    = de_q & ~vin.de;
    assign frame_end   = vs_q & ~vin.vs;
    assign frame_gap_o = ~vin.vs;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            col_cnt  <= '0;
            line_cnt <= '0;
            de_q     <= 1'b0;
            vs_q     <= 1'b0;
            frames_o <= '0;
            width_o  <= '0;
            height_o <= '0;
        end else begin
            de_q <= vin.de;
            vs_q <= vin.vs;
            if (vin.hs) begin
                col_cnt <= '0;
            end else if (vin.de) begin
                col_cnt <= col_cnt + 1'b1;
            end
            // held at zero through the gap
            if (!vin.vs) begin
                line_cnt <= '0;
            end else if (line_end) begin
                line_cnt <= line_cnt + 1'b1;
            end
            if (line_end) begin
                width_o <= col_cnt;
            end
            if (frame_end) begin
                height_o <= line_cnt + {{(`BIN_COL_WIDTH-1){1'b0}}, line_end};
                if (mode_i != MODE_OFF) begin
                    frames_o <= frames_o + 1'b1;
                end
            end
        end
    end

    assign pos_o.col        = col_cnt;
    assign pos_o.col_odd    = col_cnt[0];
    assign pos_o.line_odd   = line_cnt[0];
    assign pos_o.line_start = vin.hs;

endmodule

/* frame_mode_fsm.sv */
// mode FSM that moves the data path to the requested mode only inside a frame gap
`timescale 1ns/100ps

module frame_mode_fsm
    import bin2x2_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      ctrl_en_i,
    input  logic      ctrl_bypass_i,
    input  logic      frame_gap_i,
    output out_mode_e mode_o
);

    mode_state_e state;
    out_mode_e   req_mode;

    // steady state for a given mode
    function automatic mode_state_e state_of(input out_mode_e m);
        case (m)
            MODE_BIN:  return ST_BIN;
            MODE_PASS: return ST_BYPASS;
            default:   return ST_OFF;
        endcase
    endfunction

    assign req_mode = !ctrl_en_i    ? MODE_OFF  :
                      ctrl_bypass_i ? MODE_PASS : MODE_BIN;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state  <= ST_OFF;
            mode_o <= MODE_OFF;
        end else begin
            case (state)
                ST_WAIT_GAP: begin
                    // old mode holds until the gap
                    if (frame_gap_i) begin
                        state  <= state_of(req_mode);
                        mode_o <= req_mode;
                    end
                end
                default: begin
                    if (state_of(req_mode) != state) begin
                        if (frame_gap_i) begin
                            state  <= state_of(req_mode);
                            mode_o <= req_mode;
                        end else begin
                            state <= ST_WAIT_GAP;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* wb_csr_regs.sv */
// wishbone classic slave with the control register and read-only status registers
`timescale 1ns/100ps
`include "bin2x2_consts.svh"

module wb_csr_regs
    import bin2x2_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  csr_addr_e                       wb_adr_i,
    input  logic [`BIN_WB_DATA_WIDTH-1:0]   wb_dat_i,
    input  logic [`BIN_WB_DATA_WIDTH/8-1:0] wb_sel_i,
    output logic [`BIN_WB_DATA_WIDTH-1:0]   wb_dat_o,
    output logic                            wb_ack_o,
    input  logic [`BIN_WB_DATA_WIDTH-1:0]   frames_i,
    input  logic [`BIN_COL_WIDTH-1:0]       width_i,
    input  logic [`BIN_COL_WIDTH-1:0]       height_i,
    output logic                            ctrl_en_o,
    output logic                            ctrl_bypass_o
);

    logic                          req;
    logic [`BIN_WB_DATA_WIDTH-1:0] rd_data;

    // new request, masked during the ack cycle
    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o      <= 1'b0;
            ctrl_en_o     <= 1'b0;
            ctrl_bypass_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
            // only byte lane 0 holds writable bits
            if (req && wb_we_i && (wb_adr_i == REG_CTRL) && wb_sel_i[0]) begin
                ctrl_en_o     <= wb_dat_i[0];
                ctrl_bypass_o <= wb_dat_i[1];
            end
        end
    end

    // ------------------------------
    // read mux
    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            REG_CTRL:   rd_data[1:0] = {ctrl_bypass_o, ctrl_en_o};
            REG_FRAMES: rd_data = frames_i;
            REG_WIDTH:  rd_data[`BIN_COL_WIDTH-1:0] = width_i;
            REG_HEIGHT: rd_data[`BIN_COL_WIDTH-1:0] = height_i;
            default:    rd_data = '0;
        endcase
    end

    // read data lands together with ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

/* video_if.sv */
// video stream bundle, one pixel per clock; src drives the stream, snk samples it
`timescale 1ns/100ps
`include "bin2x2_consts.svh"

interface video_if;

    // pixel value
    logic [`BIN_PIXEL_WIDTH-1:0] data;
    // pixel valid
    logic de;
    // line pulse, ahead of each line
    logic hs;
    // frame active
    logic vs;

    modport src (
        output data,
        output de,
        output hs,
        output vs
    );

    modport snk (
        input data,
        input de,
        input hs,
        input vs
    );

endinterface

/* bin2x2_pkg.sv */
// shared types for the 2x2 binning block, imported by wildcard in each module header
`include "bin2x2_consts.svh"

package bin2x2_pkg;

    // ------------------------------
    // register map, word addresses
    typedef enum logic [`BIN_WB_ADDR_WIDTH-1:0] {
        REG_CTRL   = 2'd0,
        REG_FRAMES = 2'd1,
        REG_WIDTH  = 2'd2,
        REG_HEIGHT = 2'd3
    } csr_addr_e;

    // mode FSM states
    typedef enum logic [1:0] {
        ST_OFF      = 2'd0,
        ST_WAIT_GAP = 2'd1,
        ST_BIN      = 2'd2,
        ST_BYPASS   = 2'd3
    } mode_state_e;

    // data path mode seen by the pipe and the counter
    typedef enum logic [1:0] {
        MODE_OFF  = 2'd0,
        MODE_BIN  = 2'd1,
        MODE_PASS = 2'd2
    } out_mode_e;

    // position of the pixel currently on the input
    typedef struct packed {
        logic [`BIN_COL_WIDTH-1:0] col;
        logic                      col_odd;
        logic                      line_odd;
        logic                      line_start;
    } pix_pos_t;

endpackage

/* bin2x2_consts.svh */
// width and depth macros for the 2x2 binning block, pulled in with `include
`ifndef BIN2X2_CONSTS_SVH
`define BIN2X2_CONSTS_SVH

// ------------------------------
// video
// bits per pixel
`define BIN_PIXEL_WIDTH 8

// line buffer depth, longest supported line
`define BIN_LINE_MAX 1024

// column and line counter width
`define BIN_COL_WIDTH 11

// ------------------------------
// wishbone
// word address, four registers
`define BIN_WB_ADDR_WIDTH 2
`define BIN_WB_DATA_WIDTH 32

`endif
